// File: sources.f
verilog/ex_isa_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_csr_regs.sv
verilog/ex_stage.sv
verilog/ex_core.sv
test/ex_core_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
  -f sources.f --top-module ex_core_tb -Mdir obj_dir
./obj_dir/Vex_core_tb

// File: test/ex_core_tb.sv
// Testbench for ex_core with an instruction table, writeback monitor and random back-pressure
`default_nettype none

module ex_core_tb
  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_ROWS   = 40;
  localparam int U_ALU      = 0;
  localparam int U_MUL      = 1;
  localparam int U_CSR      = 2;
  localparam int NO_KILL    = 0;
  localparam int KILL_ISSUE = 1;
  localparam int KILL_MULT  = 2;
  // Cycles a multiply runs before it is killed
  localparam int MULT_HOLD  = 5;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  logic                  alu_en_i;
  logic                  mult_en_i;
  logic                  csr_en_i;
  alu_op_e               alu_op_i;
  mult_op_e              mult_op_i;
  csr_op_e               csr_op_i;
  logic [XLEN-1:0]       operand_a_i;
  logic [XLEN-1:0]       operand_b_i;
  logic [XLEN-1:0]       operand_c_i;
  logic                  rf_we_i;
  logic [RF_ADDR_W-1:0]  rf_waddr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  kill_ex_i;
  logic                  halt_ex_i;
  logic                  rf_we_ex_o;
  logic [RF_ADDR_W-1:0]  rf_waddr_ex_o;
  logic [XLEN-1:0]       rf_wdata_ex_o;
  logic                  branch_decision_o;
  logic [XLEN-1:0]       branch_target_o;
  logic                  ex_ready_o;
  logic                  wb_valid_o;
  logic                  wb_ready_i;
  logic                  wb_rf_we_o;
  logic [RF_ADDR_W-1:0]  wb_rf_waddr_o;
  logic [XLEN-1:0]       wb_rf_wdata_o;
  logic [XLEN-1:0]       wb_pc_o;
  logic                  wb_csr_en_o;
  csr_op_e               wb_csr_op_o;
  logic [CSR_ADDR_W-1:0] wb_csr_addr_o;
  logic [XLEN-1:0]       wb_csr_wdata_o;

  // Instruction table with one entry per row
  string                row_name    [MAX_ROWS];
  int                   row_unit    [MAX_ROWS];
  alu_op_e              row_alu_op  [MAX_ROWS];
  mult_op_e             row_mult_op [MAX_ROWS];
  csr_op_e              row_csr_op  [MAX_ROWS];
  logic [XLEN-1:0]      row_a       [MAX_ROWS];
  logic [XLEN-1:0]      row_b       [MAX_ROWS];
  logic [XLEN-1:0]      row_c       [MAX_ROWS];
  logic [RF_ADDR_W-1:0] row_rd      [MAX_ROWS];
  logic                 row_we      [MAX_ROWS];
  logic [XLEN-1:0]      row_exp     [MAX_ROWS];
  logic                 row_br      [MAX_ROWS];
  int                   row_kill    [MAX_ROWS];

  // Rows expected at writeback in issue order
  int exp_order [MAX_ROWS];
  int n_rows      = 0;
  int n_expected  = 0;
  int exp_ptr     = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  ex_core u_ex_core (.*);

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h actual %h", what, exp, act));
  endtask

  // Every row gets a distinct PC so a lost or doubled item shows up at once
  function automatic logic [XLEN-1:0] pc_of(input int i);
    return XLEN'(32'h1000 + 4 * i);
  endfunction

  task automatic new_row(input string name, input int unit, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] c,
                         input logic [RF_ADDR_W-1:0] rd, input logic we,
                         input logic [XLEN-1:0] exp, input logic br, input int kill);
    row_name[n_rows]    = name;
    row_unit[n_rows]    = unit;
    row_alu_op[n_rows]  = ALU_ADD;
    row_mult_op[n_rows] = MUL_LO;
    row_csr_op[n_rows]  = CSR_OP_READ;
    row_a[n_rows]       = a;
    row_b[n_rows]       = b;
    row_c[n_rows]       = c;
    row_rd[n_rows]      = rd;
    row_we[n_rows]      = we;
    row_exp[n_rows]     = exp;
    row_br[n_rows]      = br;
    row_kill[n_rows]    = kill;
    // Killed rows never reach writeback
    if (kill == NO_KILL)
    begin
      exp_order[n_expected] = n_rows;
      n_expected++;
    end
    n_rows++;
  endtask

  task automatic alu_row(input string name, input alu_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] c,
                         input logic [RF_ADDR_W-1:0] rd, input logic [XLEN-1:0] exp,
                         input logic br, input int kill);
    // Branch compares write no register
    new_row(name, U_ALU, a, b, c, rd, (op < ALU_EQ), exp, br, kill);
    row_alu_op[n_rows-1] = op;
  endtask

  task automatic mul_row(input string name, input mult_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b, input logic [RF_ADDR_W-1:0] rd,
                         input logic [XLEN-1:0] exp, input int kill);
    new_row(name, U_MUL, a, b, 32'h0, rd, 1'b1, exp, 1'b0, kill);
    row_mult_op[n_rows-1] = op;
  endtask

  task automatic csr_row(input string name, input csr_op_e op, input logic [XLEN-1:0] a,
                         input logic [CSR_ADDR_W-1:0] addr, input logic [RF_ADDR_W-1:0] rd,
                         input logic [XLEN-1:0] exp);
    new_row(name, U_CSR, a, XLEN'(addr), 32'h0, rd, 1'b1, exp, 1'b0, NO_KILL);
    row_csr_op[n_rows-1] = op;
  endtask

  ////////////////////////////////////////////////////////////
  // Instruction table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    alu_row("add_ovf",   ALU_ADD,  32'h7fffffff, 32'h1, 32'h0, 5'd1, 32'h80000000, 1'b0, NO_KILL);
    alu_row("sub_neg",   ALU_SUB,  32'h5, 32'h7, 32'h0, 5'd2, 32'hfffffffe, 1'b0, NO_KILL);
    alu_row("and",       ALU_AND,  32'hf0f0f0f0, 32'h0ff00ff0, 32'h0, 5'd3, 32'h00f000f0,
            1'b0, NO_KILL);
    alu_row("or",        ALU_OR,   32'hf0f0f0f0, 32'h0ff00ff0, 32'h0, 5'd4, 32'hfff0fff0,
            1'b0, NO_KILL);
    alu_row("xor",       ALU_XOR,  32'hf0f0f0f0, 32'h0ff00ff0, 32'h0, 5'd5, 32'hff00ff00,
            1'b0, NO_KILL);
    // Shift amount 0x24 keeps only its low five bits
    alu_row("sll_mask",  ALU_SLL,  32'h1, 32'h24, 32'h0, 5'd6, 32'h10, 1'b0, NO_KILL);
    alu_row("srl",       ALU_SRL,  32'h80000000, 32'h1f, 32'h0, 5'd7, 32'h1, 1'b0, NO_KILL);
    alu_row("sra_neg",   ALU_SRA,  32'h80000000, 32'h4, 32'h0, 5'd8, 32'hf8000000, 1'b0, NO_KILL);
    alu_row("slt_neg",   ALU_SLT,  32'hffffffff, 32'h1, 32'h0, 5'd9, 32'h1, 1'b0, NO_KILL);
    alu_row("sltu_big",  ALU_SLTU, 32'hffffffff, 32'h1, 32'h0, 5'd10, 32'h0, 1'b0, NO_KILL);
    // Branches with the target in operand C
    alu_row("beq_take",  ALU_EQ,   32'h1234, 32'h1234, 32'h2000, 5'd0, 32'h1, 1'b1, NO_KILL);
    alu_row("bne_fall",  ALU_NE,   32'h1234, 32'h1234, 32'h2004, 5'd0, 32'h0, 1'b0, NO_KILL);
    alu_row("blt_take",  ALU_LT,   32'h80000000, 32'h0, 32'h2008, 5'd0, 32'h1, 1'b1, NO_KILL);
    alu_row("bge_fall",  ALU_GE,   32'h80000000, 32'h0, 32'h200c, 5'd0, 32'h0, 1'b0, NO_KILL);
    alu_row("bltu_fall", ALU_LTU,  32'h80000000, 32'h0, 32'h2010, 5'd0, 32'h0, 1'b0, NO_KILL);
    alu_row("bgeu_take", ALU_GEU,  32'h80000000, 32'h0, 32'h2014, 5'd0, 32'h1, 1'b1, NO_KILL);
    alu_row("add_killed", ALU_ADD, 32'h1, 32'h1, 32'h0, 5'd11, 32'h2, 1'b0, KILL_ISSUE);
    // Most negative times minus one in all four forms
    mul_row("mul_lo_min",  MUL_LO,    32'h80000000, 32'hffffffff, 5'd12, 32'h80000000, NO_KILL);
    mul_row("mulh_ss_min", MUL_HI_SS, 32'h80000000, 32'hffffffff, 5'd13, 32'h00000000, NO_KILL);
    mul_row("mulh_uu_min", MUL_HI_UU, 32'h80000000, 32'hffffffff, 5'd14, 32'h7fffffff, NO_KILL);
    mul_row("mulh_su_min", MUL_HI_SU, 32'h80000000, 32'hffffffff, 5'd15, 32'h80000000, NO_KILL);
    mul_row("mul_lo_neg",  MUL_LO,    32'h7, 32'hfffffffd, 5'd16, 32'hffffffeb, NO_KILL);
    mul_row("mulh_ss_neg", MUL_HI_SS, 32'h7, 32'hfffffffd, 5'd17, 32'hffffffff, NO_KILL);
    mul_row("mulh_uu_max", MUL_HI_UU, 32'hffffffff, 32'hffffffff, 5'd18, 32'hfffffffe, NO_KILL);
    mul_row("mulh_su_max", MUL_HI_SU, 32'hffffffff, 32'hffffffff, 5'd19, 32'hffffffff, NO_KILL);
    mul_row("mul_killed",  MUL_LO,    32'h3, 32'h5, 5'd20, 32'hf, KILL_MULT);
    mul_row("mul_after_kill", MUL_LO, 32'h12345, 32'h10, 5'd21, 32'h123450, NO_KILL);
    // CSR sequence with a gap row so each commit lands before the next read
    csr_row("csrw", CSR_OP_WRITE, 32'h000000f0, 12'h341, 5'd22, 32'h0);
    alu_row("gap_0", ALU_ADD, 32'h1, 32'h2, 32'h0, 5'd23, 32'h3, 1'b0, NO_KILL);
    csr_row("csrs", CSR_OP_SET, 32'h0f00000f, 12'h341, 5'd24, 32'h000000f0);
    alu_row("gap_1", ALU_ADD, 32'h3, 32'h4, 32'h0, 5'd25, 32'h7, 1'b0, NO_KILL);
    csr_row("csrc", CSR_OP_CLEAR, 32'h000000f0, 12'h341, 5'd26, 32'h0f0000ff);
    alu_row("gap_2", ALU_ADD, 32'h10, 32'h20, 32'h0, 5'd27, 32'h30, 1'b0, NO_KILL);
    csr_row("csrr", CSR_OP_READ, 32'h0, 12'h341, 5'd28, 32'h0f00000f);
    csr_row("csrr_unmapped", CSR_OP_READ, 32'h0, 12'h345, 5'd29, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // Issue driver and writeback monitor
  ////////////////////////////////////////////////////////////

  task automatic apply_row(input int i);
    logic accepted;
    logic first;
    accepted      = 1'b0;
    first         = 1'b1;
    instr_valid_i = 1'b1;
    alu_en_i      = (row_unit[i] == U_ALU);
    mult_en_i     = (row_unit[i] == U_MUL);
    csr_en_i      = (row_unit[i] == U_CSR);
    alu_op_i      = row_alu_op[i];
    mult_op_i     = row_mult_op[i];
    csr_op_i      = row_csr_op[i];
    operand_a_i   = row_a[i];
    operand_b_i   = row_b[i];
    operand_c_i   = row_c[i];
    rf_we_i       = row_we[i];
    rf_waddr_i    = row_rd[i];
    pc_i          = pc_of(i);
    if (row_kill[i] != NO_KILL)
    begin
      // Multiply gets a head start before the kill
      if (row_kill[i] == KILL_MULT)
      begin
        repeat (MULT_HOLD) @(posedge clk);
        #1;
      end
      kill_ex_i = 1'b1;
      @(negedge clk);
      // A killed instruction forwards no register write
      check_value({row_name[i], " rf_we_ex"}, '0, XLEN'(rf_we_ex_o));
      @(posedge clk);
      #1;
      kill_ex_i = 1'b0;
    end
    else
    begin
      // Hold the payload until the stage takes it
      while (!accepted)
      begin
        @(negedge clk);
        if (first && (row_unit[i] == U_ALU) && !row_we[i])
        begin
          check_value({row_name[i], " branch_decision"}, XLEN'(row_br[i]),
                      XLEN'(branch_decision_o));
          check_value({row_name[i], " branch_target"}, row_c[i], branch_target_o);
        end
        first    = 1'b0;
        accepted = ex_ready_o;
        if (accepted)
        begin
          // Forwarding view of the instruction as it is taken
          check_value({row_name[i], " rf_we_ex"}, XLEN'(row_we[i]), XLEN'(rf_we_ex_o));
          check_value({row_name[i], " rf_waddr_ex"}, XLEN'(row_rd[i]), XLEN'(rf_waddr_ex_o));
          check_value({row_name[i], " rf_wdata_ex"}, row_exp[i], rf_wdata_ex_o);
        end
        @(posedge clk);
        #1;
      end
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic take_writeback();
    int idx;
    if (exp_ptr >= n_expected)
      fail_run("Writeback transfer seen after every expected instruction had retired");
    else
    begin
      idx = exp_order[exp_ptr];
      // PC first since a dropped or repeated item then names itself
      check_value({row_name[idx], " pc"}, pc_of(idx), wb_pc_o);
      check_value({row_name[idx], " rf_we"}, XLEN'(row_we[idx]), XLEN'(wb_rf_we_o));
      check_value({row_name[idx], " rf_waddr"}, XLEN'(row_rd[idx]), XLEN'(wb_rf_waddr_o));
      check_value({row_name[idx], " rf_wdata"}, row_exp[idx], wb_rf_wdata_o);
      check_value({row_name[idx], " csr_en"}, XLEN'(row_unit[idx] == U_CSR),
                  XLEN'(wb_csr_en_o));
      if (row_unit[idx] == U_CSR)
      begin
        check_value({row_name[idx], " csr_addr"}, row_b[idx], XLEN'(wb_csr_addr_o));
        check_value({row_name[idx], " csr_op"}, XLEN'(row_csr_op[idx]), XLEN'(wb_csr_op_o));
        check_value({row_name[idx], " csr_wdata"}, row_a[idx], wb_csr_wdata_o);
      end
      exp_ptr++;
    end
  endtask

  // Outputs are settled mid-cycle
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (rst_n && wb_valid_o && wb_ready_i)
        take_writeback();
    end
  end

  ////////////////////////////////////////////////////////////
  // Clock, back-pressure and timeout
  ////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Writeback stalls about three cycles in ten
  initial
  begin
    void'($urandom(32'h94d83c8e));
    wb_ready_i = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      wb_ready_i = (($urandom % 100) >= 30);
    end
  end

  initial
  begin
    @(posedge rst_n);
    while (cycle_cnt <= cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    fail_run("Timeout, the instruction table did not complete in time");
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    alu_en_i      = 1'b0;
    mult_en_i     = 1'b0;
    csr_en_i      = 1'b0;
    alu_op_i      = ALU_ADD;
    mult_op_i     = MUL_LO;
    csr_op_i      = CSR_OP_READ;
    operand_a_i   = '0;
    operand_b_i   = '0;
    operand_c_i   = '0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    pc_i          = '0;
    kill_ex_i     = 1'b0;
    halt_ex_i     = 1'b0;
    build_table();
    // Worst case is a full multiply plus some stalls for every row
    cycle_limit = n_rows * (MULT_ITER + 10);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    // Drain the last items and leave time for a stray one to show
    while (exp_ptr < n_expected)
      @(posedge clk);
    repeat (10) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ex_core.sv
// Top level joining the execute stage and the scratch CSR block
`default_nettype none

module ex_core import ex_isa_pkg::*; import ex_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Issue side
  input  logic                  instr_valid_i,
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_en_i,
  input  alu_op_e               alu_op_i,
  input  mult_op_e              mult_op_i,
  input  csr_op_e               csr_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  logic                  rf_we_i,
  input  logic [RF_ADDR_W-1:0]  rf_waddr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  kill_ex_i,
  input  logic                  halt_ex_i,

  // Forwarding and branch
  output logic                  rf_we_ex_o,
  output logic [RF_ADDR_W-1:0]  rf_waddr_ex_o,
  output logic [XLEN-1:0]       rf_wdata_ex_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       branch_target_o,

  output logic                  ex_ready_o,

  // Writeback side
  output logic                  wb_valid_o,
  input  logic                  wb_ready_i,
  output logic                  wb_rf_we_o,
  output logic [RF_ADDR_W-1:0]  wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic [XLEN-1:0]       wb_pc_o,
  output logic                  wb_csr_en_o,
  output csr_op_e               wb_csr_op_o,
  output logic [CSR_ADDR_W-1:0] wb_csr_addr_o,
  output logic [XLEN-1:0]       wb_csr_wdata_o
);

  logic [CSR_ADDR_W-1:0] csr_raddr;
  logic [XLEN-1:0]       csr_rdata;

  // Port names match the top level except the CSR read pair
  ex_stage u_ex_stage
  (
    .csr_raddr_o (csr_raddr),
    .csr_rdata_i (csr_rdata),
    .*
  );

  // CSR writes commit as the item leaves EX/WB
  ex_csr_regs u_ex_csr_regs
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .raddr_i    (csr_raddr),
    .rdata_o    (csr_rdata),
    .wb_valid_i (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .csr_en_i   (wb_csr_en_o),
    .csr_op_i   (wb_csr_op_o),
    .waddr_i    (wb_csr_addr_o),
    .wdata_i    (wb_csr_wdata_o)
  );

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
// Execute stage with enable gating, write-data mux, branch outputs and EX/WB register
`default_nettype none

module ex_stage import ex_isa_pkg::*; import ex_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Issue side
  input  logic                  instr_valid_i,
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_en_i,
  input  alu_op_e               alu_op_i,
  input  mult_op_e              mult_op_i,
  input  csr_op_e               csr_op_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [XLEN-1:0]       operand_c_i,
  input  logic                  rf_we_i,
  input  logic [RF_ADDR_W-1:0]  rf_waddr_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic                  kill_ex_i,
  input  logic                  halt_ex_i,

  // CSR read
  input  logic [XLEN-1:0]       csr_rdata_i,
  output logic [CSR_ADDR_W-1:0] csr_raddr_o,

  // Forwarding and branch
  output logic                  rf_we_ex_o,
  output logic [RF_ADDR_W-1:0]  rf_waddr_ex_o,
  output logic [XLEN-1:0]       rf_wdata_ex_o,
  output logic                  branch_decision_o,
  output logic [XLEN-1:0]       branch_target_o,

  output logic                  ex_ready_o,

  // Writeback side
  output logic                  wb_valid_o,
  input  logic                  wb_ready_i,
  output logic                  wb_rf_we_o,
  output logic [RF_ADDR_W-1:0]  wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o,
  output logic [XLEN-1:0]       wb_pc_o,
  output logic                  wb_csr_en_o,
  output csr_op_e               wb_csr_op_o,
  output logic [CSR_ADDR_W-1:0] wb_csr_addr_o,
  output logic [XLEN-1:0]       wb_csr_wdata_o
);

  logic            instr_valid;
  logic            alu_en_gated;
  logic            mult_en_gated;
  logic            csr_en_gated;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp_result;
  logic [XLEN-1:0] mult_result;
  logic            mult_ready;
  logic            ex_valid;

  // Killed instructions enable nothing
  assign instr_valid   = instr_valid_i && !kill_ex_i;
  assign alu_en_gated  = alu_en_i && instr_valid;
  assign mult_en_gated = mult_en_i && instr_valid;
  assign csr_en_gated  = csr_en_i && instr_valid;

  assign csr_raddr_o = operand_b_i[CSR_ADDR_W-1:0];

  // Forwarding view of the current instruction
  // CSR instructions forward the old CSR value
  assign rf_we_ex_o    = rf_we_i && instr_valid;
  assign rf_waddr_ex_o = rf_waddr_i;
  always_comb
  begin
    rf_wdata_ex_o = '0;
    if (alu_en_gated)
      rf_wdata_ex_o = alu_result;
    if (mult_en_gated)
      rf_wdata_ex_o = mult_result;
    if (csr_en_gated)
      rf_wdata_ex_o = csr_rdata_i;
  end

  // Branch decision from the compare, target precomputed in operand C
  assign branch_decision_o = alu_cmp_result;
  assign branch_target_o   = operand_c_i;

  ex_alu u_ex_alu
  (
    .operator_i          (alu_op_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result)
  );

  ex_mult u_ex_mult
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .kill_i     (kill_ex_i),
    .enable_i   (mult_en_gated),
    .operator_i (mult_op_i),
    .op_a_i     (operand_a_i),
    .op_b_i     (operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ////////////////////////////////////////////////////////////
  // Stall logic
  ////////////////////////////////////////////////////////////

  // ALU finishes in its cycle, so only the multiplier can hold EX
  assign ex_ready_o = mult_ready && wb_ready_i && !halt_ex_i;
  // Halt only blocks acceptance upstream
  assign ex_valid   = mult_ready && wb_ready_i && instr_valid;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_csr_en_o <= 1'b0;
    end
    else if (ex_valid)
    begin
      wb_valid_o  <= 1'b1;
      wb_rf_we_o  <= rf_we_i;
      wb_csr_en_o <= csr_en_i;
    end
    else if (wb_ready_i)
    begin
      // Drained with nothing new, insert a bubble
      wb_valid_o  <= 1'b0;
      wb_rf_we_o  <= 1'b0;
      wb_csr_en_o <= 1'b0;
    end
  end

  // Payload only moves together with a new item
  always_ff @(posedge clk)
  begin
    if (ex_valid)
    begin
      wb_rf_waddr_o  <= rf_waddr_i;
      wb_rf_wdata_o  <= rf_wdata_ex_o;
      wb_pc_o        <= pc_i;
      wb_csr_op_o    <= csr_op_i;
      wb_csr_addr_o  <= operand_b_i[CSR_ADDR_W-1:0];
      wb_csr_wdata_o <= operand_a_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ex_csr_regs.sv
// Four machine scratch CSRs with combinational read and writeback commit
`default_nettype none

module ex_csr_regs import ex_isa_pkg::*; import ex_pipe_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Read port from EX
  input  logic [CSR_ADDR_W-1:0] raddr_i,
  output logic [XLEN-1:0]       rdata_o,

  // Commit from the EX/WB register
  input  logic                  wb_valid_i,
  input  logic                  wb_ready_i,
  input  logic                  csr_en_i,
  input  csr_op_e               csr_op_i,
  input  logic [CSR_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  logic [XLEN-1:0] scratch_q [4];
  logic            rd_hit;
  logic            wr_hit;
  logic            commit;

  // Upper address bits select the scratch block, low two bits the register
  assign rd_hit  = (raddr_i[CSR_ADDR_W-1:2] == CSR_SCRATCH_BASE[CSR_ADDR_W-1:2]);
  assign wr_hit  = (waddr_i[CSR_ADDR_W-1:2] == CSR_SCRATCH_BASE[CSR_ADDR_W-1:2]);
  assign rdata_o = rd_hit ? scratch_q[raddr_i[1:0]] : '0;    // unmapped reads as zero

  // Commit only when the item actually leaves EX/WB
  assign commit = wb_valid_i && wb_ready_i && csr_en_i && wr_hit;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      scratch_q <= '{default: '0};
    else if (commit)
    begin
      case (csr_op_i)
        CSR_OP_WRITE: scratch_q[waddr_i[1:0]] <= wdata_i;
        CSR_OP_SET:   scratch_q[waddr_i[1:0]] <= scratch_q[waddr_i[1:0]] | wdata_i;
        CSR_OP_CLEAR: scratch_q[waddr_i[1:0]] <= scratch_q[waddr_i[1:0]] & ~wdata_i;
        default:      scratch_q[waddr_i[1:0]] <= scratch_q[waddr_i[1:0]];
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/ex_mult.sv
// Iterative shift-add multiplier FSM with low and high product words
`default_nettype none

module ex_mult import ex_isa_pkg::*; import ex_pipe_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  input  logic            kill_i,
  input  logic            enable_i,
  input  mult_op_e        operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  input  logic            ex_ready_i,

  output logic [XLEN-1:0] result_o,
  output logic            ready_o
);

  typedef enum logic [1:0] {IDLE, CALC, DONE} mult_state_e;

  mult_state_e            state_q;
  mult_state_e            state_d;
  logic [MULT_CNT_W-1:0]  cnt_q;
  logic                   a_neg;
  logic                   b_neg;
  logic [XLEN-1:0]        a_mag;
  logic [XLEN-1:0]        b_mag;
  logic [2*XLEN-1:0]      mcand_q;
  logic [2*XLEN-1:0]      prod_q;
  logic [2*XLEN-1:0]      prod_fixed;
  logic [XLEN-1:0]        mplier_q;
  logic                   neg_q;
  mult_op_e               op_q;

  // Operand signs per operator
  // Low word is the same for any signedness, so treat it as unsigned
  assign a_neg = ((operator_i == MUL_HI_SS) || (operator_i == MUL_HI_SU)) && op_a_i[XLEN-1];
  assign b_neg = (operator_i == MUL_HI_SS) && op_b_i[XLEN-1];
  assign a_mag = a_neg ? -op_a_i : op_a_i;
  assign b_mag = b_neg ? -op_b_i : op_b_i;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    ready_o = 1'b0;
    case (state_q)
      IDLE:
      begin
        ready_o = !enable_i;
        if (enable_i)
          state_d = CALC;
      end
      CALC:
      begin
        // Bit 0 was done on entry, so the last step is bit MULT_ITER-1
        if (cnt_q == MULT_CNT_W'(MULT_ITER - 1))
          state_d = DONE;
      end
      DONE:
      begin
        ready_o = 1'b1;
        if (ex_ready_i)
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    // Kill aborts from any state
    if (kill_i)
      state_d = IDLE;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == IDLE)
        cnt_q <= MULT_CNT_W'(1);
      else if (state_q == CALC)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Shift-add datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if ((state_q == IDLE) && enable_i)
    begin
      // Latch magnitudes and do the bit-0 step at once
      op_q     <= operator_i;
      neg_q    <= a_neg ^ b_neg;
      mcand_q  <= {{XLEN{1'b0}}, a_mag} << 1;
      mplier_q <= b_mag >> 1;
      prod_q   <= b_mag[0] ? {{XLEN{1'b0}}, a_mag} : '0;
    end
    else if (state_q == CALC)
    begin
      if (mplier_q[0])
        prod_q <= prod_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Sign fix and word select, valid in DONE
  assign prod_fixed = neg_q ? -prod_q : prod_q;
  assign result_o   = (op_q == MUL_LO) ? prod_fixed[XLEN-1:0] : prod_fixed[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: verilog/ex_alu.sv
// Combinational ALU with add, logic, shift, set-less-than and branch compares
`default_nettype none

module ex_alu import ex_isa_pkg::*; import ex_pipe_pkg::*;
(
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,

  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o
);

  logic [4:0] shamt;
  logic       is_eq;
  logic       is_lt;
  logic       is_ltu;

  // Only the low five bits of B count as a shift amount
  assign shamt = operand_b_i[4:0];

  ////////////////////////////////////////////////////////////
  // Comparisons
  ////////////////////////////////////////////////////////////

  assign is_eq  = (operand_a_i == operand_b_i);
  assign is_lt  = ($signed(operand_a_i) < $signed(operand_b_i));
  assign is_ltu = (operand_a_i < operand_b_i);

  // Set-less-than shares the compare path with the branches
  always_comb
  begin
    comparison_result_o = 1'b0;
    case (operator_i)
      ALU_SLT, ALU_LT:   comparison_result_o = is_lt;
      ALU_SLTU, ALU_LTU: comparison_result_o = is_ltu;
      ALU_EQ:            comparison_result_o = is_eq;
      ALU_NE:            comparison_result_o = !is_eq;
      ALU_GE:            comparison_result_o = !is_lt;
      ALU_GEU:           comparison_result_o = !is_ltu;
      default:           comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign of A
      ALU_SRA: result_o = $signed(operand_a_i) >>> shamt;
      // Compares give 0 or 1
      default: result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/ex_pipe_pkg.sv
// Pipeline widths, scratch CSR map and multiplier iteration constants
`default_nettype none

package ex_pipe_pkg;

  // Datapath and register-file address widths
  localparam int XLEN      = 32;
  localparam int RF_ADDR_W = 5;

  // CSR address space
  localparam int CSR_ADDR_W = 12;

  // First of four consecutive machine scratch registers
  localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH_BASE = 12'h340;

  // One shift-add step per multiplier bit
  localparam int MULT_ITER  = 32;
  localparam int MULT_CNT_W = $clog2(MULT_ITER);

endpackage

`default_nettype wire

// File: verilog/ex_isa_pkg.sv
// Instruction-set enums for the ALU, multiplier and CSR operators
`default_nettype none

package ex_isa_pkg;

  // ALU operators
  // The last six are branch compares and only drive the compare flag
  typedef enum logic [3:0]
  {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators, low word or one of three high-word signedness forms
  typedef enum logic [1:0]
  {
    MUL_LO    = 2'b00,
    MUL_HI_SS = 2'b01,
    MUL_HI_UU = 2'b10,
    MUL_HI_SU = 2'b11
  } mult_op_e;

  // CSR access kinds
  typedef enum logic [1:0]
  {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

endpackage

`default_nettype wire
